//--- Makefile
# Verilator build and run of the memory subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_memory_subsystem
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# The log decides pass or fail.
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_memory_subsystem.sv
// Testbench for the memory subsystem, checking random fetches and data accesses against a model.
`default_nettype none
`timescale 1ns/1ps

module tb_memory_subsystem import cpu_pkg::*; ();

	localparam int MEM_WORDS  = 1024;
	localparam int CACHE_SETS = 64;
	localparam int WAIT_LIMIT = 200;

	logic  i_clock = 1'b0;
	logic  i_reset;
	word_t i_fetch_pc;
	word_t o_fetch_data;
	logic  o_fetch_ready;
	logic  i_data_request;
	logic  i_data_write;
	word_t i_data_address;
	word_t i_data_wdata;
	logic  o_data_ready;
	word_t o_data_rdata;
	word_t o_hit_count;
	word_t o_refill_count;

	// Reference model of the memory words and of the cache tags that predict refills.
	word_t       mem_model [0:MEM_WORDS-1];
	logic        tag_valid [0:CACHE_SETS-1];
	logic [23:0] tag_model [0:CACHE_SETS-1];
	word_t       refill_model;
	integer      seed = 41012;

	cpu_memory_subsystem u_dut (.*);

	always #5 i_clock = ~i_clock;

	// Inputs change 1 ns after the rising edge.
	task automatic step();
		@(posedge i_clock);
		#1;
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, expected, actual));
		end
	endtask

	// Fetches one PC and compares the word and the refill count with the model.
	task automatic fetch_and_check(input string name, input word_t pc, input logic check_data);
		int          waited;
		logic [5:0]  line_set;
		logic [23:0] line_tag;
		bus_owner_t  owner;
		line_set = pc[7:2];
		line_tag = pc[31:8];
		if (!tag_valid[line_set] || tag_model[line_set] != line_tag) begin
			refill_model        = refill_model + 1;
			tag_valid[line_set] = 1'b1;
			tag_model[line_set] = line_tag;
		end
		i_fetch_pc = pc;
		waited     = 0;
		@(negedge i_clock);
		while (!o_fetch_ready) begin
			if (waited == WAIT_LIMIT) begin
				owner = u_dut.u_arbiter.owner;
				fail_run($sformatf("fetch of %h never became ready, bus owner %s",
					pc, owner.name()));
			end
			waited++;
			@(negedge i_clock);
		end
		if (check_data) begin
			check_word(name, mem_model[pc[11:2]], o_fetch_data);
		end
		check_count({name, " refills"}, refill_model, o_refill_count);
		step();
	endtask

	// One data port transfer, then one idle cycle before the next request.
	task automatic data_access(input logic write, input word_t address, input word_t wdata,
			output word_t rdata);
		int waited;
		i_data_request = 1'b1;
		i_data_write   = write;
		i_data_address = address;
		i_data_wdata   = wdata;
		waited         = 0;
		@(negedge i_clock);
		while (!o_data_ready) begin
			if (waited == WAIT_LIMIT) begin
				fail_run($sformatf("data access to %h never became ready", address));
			end
			waited++;
			@(negedge i_clock);
		end
		rdata = o_data_rdata;
		step();
		i_data_request = 1'b0;
		step();
	endtask

	initial begin
		word_t rdata;
		word_t pc;
		word_t pc_b;
		word_t hits;
		word_t refills_before;
		int    idx;
		i_reset        = 1'b1;
		i_fetch_pc     = 32'h0000_0800;
		i_data_request = 1'b0;
		i_data_write   = 1'b0;
		i_data_address = '0;
		i_data_wdata   = '0;
		refill_model   = '0;
		for (idx = 0; idx < CACHE_SETS; idx++) begin
			tag_valid[idx] = 1'b0;
			tag_model[idx] = '0;
		end
		repeat (5) step();
		i_reset = 1'b0;

		// Clear sweep of 64 sets plus one cycle.
		@(negedge i_clock);
		check_count("reset hit count", '0, o_hit_count);
		check_count("reset refill count", '0, o_refill_count);
		for (idx = 0; idx < 65; idx++) begin
			if (o_fetch_ready || u_dut.fetch_request) begin
				fail_run("fetch became active during the clear sweep");
			end
			@(negedge i_clock);
		end
		step();
		// The parked PC in the upper half refills once, from memory not yet written.
		fetch_and_check("parked fetch", 32'h0000_0800, 1'b0);

		// Fill the whole memory, then read back at random.
		for (idx = 0; idx < MEM_WORDS; idx++) begin
			mem_model[idx] = $random(seed);
			data_access(1'b1, word_t'(idx * 4), mem_model[idx], rdata);
		end
		for (idx = 0; idx < 200; idx++) begin
			pc = $random(seed) & 32'h0000_0FFC;
			data_access(1'b0, pc, '0, rdata);
			check_word("data readback", mem_model[pc[11:2]], rdata);
		end

		// Miss, then a held PC that keeps hitting.
		pc = $random(seed) & 32'h0000_07FC;
		fetch_and_check("fetch miss", pc, 1'b1);
		hits = o_hit_count;
		repeat (3) begin
			@(negedge i_clock);
			if (!o_fetch_ready) begin
				fail_run("fetch ready dropped while the PC was held");
			end
			check_word("held fetch", mem_model[pc[11:2]], o_fetch_data);
		end
		// Ready was high in both cycles that closed during the hold.
		check_count("held hit count", hits + 2, o_hit_count);
		step();
		fetch_and_check("neighbor fetch", pc ^ 32'h0000_0004, 1'b1);
		fetch_and_check("refetch", pc, 1'b1);

		// Same set, different tags.
		pc   = $random(seed) & 32'h0000_07FC;
		pc_b = pc ^ 32'h0000_0500;
		fetch_and_check("conflict A", pc, 1'b1);
		refills_before = refill_model;
		repeat (3) begin
			fetch_and_check("conflict B", pc_b, 1'b1);
			fetch_and_check("conflict A", pc, 1'b1);
		end
		check_count("conflict refills", refills_before + 6, o_refill_count);

		// Fetches and upper-half stores compete for the bus.
		fork
			begin
				word_t fetch_pc;
				repeat (40) begin
					fetch_pc = $random(seed) & 32'h0000_07FC;
					fetch_and_check("contended fetch", fetch_pc, 1'b1);
				end
			end
			begin
				word_t store_address;
				word_t store_value;
				word_t read_value;
				repeat (40) begin
					store_address = 32'h0000_0800 | ($random(seed) & 32'h0000_07FC);
					store_value   = $random(seed);
					data_access(1'b1, store_address, store_value, read_value);
					mem_model[store_address[11:2]] = store_value;
					data_access(1'b0, store_address, '0, read_value);
					check_word("contended readback", store_value, read_value);
				end
			end
		join
		check_count("final refills", refill_model, o_refill_count);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
verilog/cpu_pkg.sv
verilog/cpu_bram_1r1w.sv
verilog/cpu_icache.sv
verilog/cpu_bus_arbiter.sv
verilog/cpu_main_memory.sv
verilog/cpu_memory_subsystem.sv
bench/tb_memory_subsystem.sv

//--- verilog/cpu_bram_1r1w.sv
// Block RAM with one registered read port and one write port.
`default_nettype none
`timescale 1ns/1ps

module cpu_bram_1r1w #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 1024
) (
	input  logic                     i_clock,

	// Read port.
	input  logic [$clog2(DEPTH)-1:0] i_read_address,
	output logic [WIDTH-1:0]         o_read_data,

	// Write port.
	input  logic                     i_write_request,
	input  logic [$clog2(DEPTH)-1:0] i_write_address,
	input  logic [WIDTH-1:0]         i_write_data
);

	logic [WIDTH-1:0] mem [0:DEPTH-1];

	// Read returns the old word when both ports hit the same address.
	always_ff @(posedge i_clock) begin
		o_read_data <= mem[i_read_address];
	end

	always_ff @(posedge i_clock) begin
		if (i_write_request) begin
			mem[i_write_address] <= i_write_data;
		end
	end

endmodule

`default_nettype wire

//--- verilog/cpu_bus_arbiter.sv
// Fixed-priority arbiter putting fetch and data requests onto one memory bus.
`default_nettype none
`timescale 1ns/1ps

module cpu_bus_arbiter import cpu_pkg::*; (
	input  logic  i_clock,
	input  logic  i_reset,

	// Fetch requester, read only.
	input  logic  i_fetch_request,
	input  word_t i_fetch_address,
	output logic  o_fetch_ready,
	output word_t o_fetch_rdata,

	// Data requester.
	input  logic  i_data_request,
	input  logic  i_data_write,
	input  word_t i_data_address,
	input  word_t i_data_wdata,
	output logic  o_data_ready,
	output word_t o_data_rdata,

	// Memory side.
	output logic  o_mem_request,
	output logic  o_mem_write,
	output word_t o_mem_address,
	output word_t o_mem_wdata,
	input  logic  i_mem_ready,
	input  word_t i_mem_rdata
);

	bus_owner_t owner;

	// Data wins when both ask in the same idle cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			owner <= BUS_OWNER_NONE;
		end else if (owner == BUS_OWNER_NONE) begin
			if (i_data_request) begin
				owner <= BUS_OWNER_DATA;
			end else if (i_fetch_request) begin
				owner <= BUS_OWNER_FETCH;
			end
		end else if (i_mem_ready) begin
			owner <= BUS_OWNER_NONE;
		end
	end

	always_comb begin
		o_mem_request = 1'b0;
		o_mem_write   = 1'b0;
		o_mem_address = i_data_address;
		o_mem_wdata   = i_data_wdata;
		case (owner)
			BUS_OWNER_DATA: begin
				o_mem_request = i_data_request;
				o_mem_write   = i_data_write;
			end
			BUS_OWNER_FETCH: begin
				o_mem_request = i_fetch_request;
				o_mem_address = i_fetch_address;
			end
			default: ;
		endcase
	end

	// Ready goes only to the current owner.
	assign o_fetch_ready = (owner == BUS_OWNER_FETCH) && i_mem_ready;
	assign o_data_ready  = (owner == BUS_OWNER_DATA) && i_mem_ready;
	assign o_fetch_rdata = i_mem_rdata;
	assign o_data_rdata  = i_mem_rdata;

endmodule

`default_nettype wire

//--- verilog/cpu_icache.sv
// Direct-mapped instruction cache, one word per line, refilled over the shared bus.
`default_nettype none
`timescale 1ns/1ps

module cpu_icache import cpu_pkg::*; #(
	parameter int CACHE_SET_BITS = 6
) (
	input  logic  i_clock,
	input  logic  i_reset,

	// Core side.
	input  word_t i_fetch_pc,
	output word_t o_fetch_data,
	output logic  o_fetch_ready,

	// Refill bus.
	output logic  o_bus_request,
	output word_t o_bus_address,
	input  logic  i_bus_ready,
	input  word_t i_bus_rdata,

	// Debug counters.
	output word_t o_hit_count,
	output word_t o_refill_count
);

	localparam int SET_COUNT = 1 << CACHE_SET_BITS;
	localparam int TAG_BITS  = WORD_BITS - BYTE_OFFSET_BITS - CACHE_SET_BITS;
	localparam int LINE_BITS = 1 + TAG_BITS + WORD_BITS;

	localparam logic [1:0] ST_CLEAR  = 2'd0;
	localparam logic [1:0] ST_LOOKUP = 2'd1;
	localparam logic [1:0] ST_REFILL = 2'd2;
	localparam logic [1:0] ST_SETTLE = 2'd3;

	logic [1:0]                state;
	logic [CACHE_SET_BITS:0]   clear_set;

	logic [CACHE_SET_BITS-1:0] pc_set;
	logic [TAG_BITS-1:0]       pc_tag;
	logic [CACHE_SET_BITS-1:0] read_set;
	logic [CACHE_SET_BITS-1:0] set_r;
	logic [LINE_BITS-1:0]      rd_line;
	logic                      ram_hit;
	logic                      hold_hit;
	logic                      lookup_miss;

	// Copy of the last line that hit, so a held PC keeps its data.
	logic                      hold_valid;
	logic [CACHE_SET_BITS-1:0] hold_set;
	logic [TAG_BITS-1:0]       hold_tag;
	word_t                     hold_data;

	logic [CACHE_SET_BITS-1:0] refill_set;
	logic [TAG_BITS-1:0]       refill_tag;
	logic                      refill_done;
	logic                      wr_request;
	logic [CACHE_SET_BITS-1:0] wr_set;
	logic [LINE_BITS-1:0]      wr_line;

	assign pc_set = i_fetch_pc[BYTE_OFFSET_BITS +: CACHE_SET_BITS];
	assign pc_tag = i_fetch_pc[WORD_BITS-1 -: TAG_BITS];

	cpu_bram_1r1w #(
		.WIDTH(LINE_BITS),
		.DEPTH(SET_COUNT)
	) u_lines (
		.i_clock(i_clock),
		.i_read_address(read_set),
		.o_read_data(rd_line),
		.i_write_request(wr_request),
		.i_write_address(wr_set),
		.i_write_data(wr_line)
	);

	// Line valid bit sits on top, then the tag, then the data word.
	assign ram_hit = (state != ST_CLEAR) && (set_r == pc_set) && rd_line[LINE_BITS-1] &&
		(rd_line[WORD_BITS +: TAG_BITS] == pc_tag);
	assign hold_hit = (state != ST_CLEAR) && hold_valid && (hold_set == pc_set) &&
		(hold_tag == pc_tag);
	assign lookup_miss = (state == ST_LOOKUP) && (set_r == pc_set) && !ram_hit && !hold_hit;

	assign o_fetch_ready = ram_hit || hold_hit;
	assign o_fetch_data  = ram_hit ? rd_line[WORD_BITS-1:0] : hold_data;

	// On a RAM hit, read ahead to the following set for sequential fetch.
	assign read_set = ram_hit ? pc_set + 1'b1 : pc_set;

	assign refill_done = (state == ST_REFILL) && i_bus_ready;

	// Clear sweep writes zeros, a refill writes the returned word as valid.
	always_comb begin
		if (state == ST_CLEAR) begin
			wr_request = (clear_set != SET_COUNT[CACHE_SET_BITS:0]);
			wr_set     = clear_set[CACHE_SET_BITS-1:0];
			wr_line    = '0;
		end else begin
			wr_request = refill_done;
			wr_set     = refill_set;
			wr_line    = {1'b1, refill_tag, i_bus_rdata};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state          <= ST_CLEAR;
			clear_set      <= '0;
			o_bus_request  <= 1'b0;
			hold_valid     <= 1'b0;
			o_hit_count    <= '0;
			o_refill_count <= '0;
		end else begin
			case (state)
				ST_CLEAR: begin
					if (wr_request) begin
						clear_set <= clear_set + 1'b1;
					end else begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (lookup_miss) begin
						o_bus_request <= 1'b1;
						state         <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state         <= ST_SETTLE;
					end
				end
				// Written line becomes readable one cycle after the write.
				default: state <= ST_LOOKUP;
			endcase

			if (wr_request) begin
				hold_valid <= 1'b0;
			end else if (ram_hit) begin
				hold_valid <= 1'b1;
			end

			if (o_fetch_ready) begin
				o_hit_count <= o_hit_count + 1'b1;
			end
			if (refill_done) begin
				o_refill_count <= o_refill_count + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		set_r <= read_set;
		if (lookup_miss) begin
			o_bus_address <= {i_fetch_pc[WORD_BITS-1:BYTE_OFFSET_BITS], {BYTE_OFFSET_BITS{1'b0}}};
			refill_set    <= pc_set;
			refill_tag    <= pc_tag;
		end
		if (ram_hit) begin
			hold_set  <= set_r;
			hold_tag  <= rd_line[WORD_BITS +: TAG_BITS];
			hold_data <= rd_line[WORD_BITS-1:0];
		end
	end

endmodule

`default_nettype wire

//--- verilog/cpu_main_memory.sv
// Main word memory with a fixed access latency and a one-cycle ready pulse.
`default_nettype none
`timescale 1ns/1ps

module cpu_main_memory import cpu_pkg::*; #(
	parameter int MEM_ADDR_BITS = 10,
	parameter int MEM_LATENCY   = 3
) (
	input  logic  i_clock,
	input  logic  i_reset,
	input  logic  i_request,
	input  logic  i_write,
	input  word_t i_address,
	input  word_t i_wdata,
	output logic  o_ready,
	output word_t o_rdata
);

	localparam int COUNT_BITS = $clog2(MEM_LATENCY + 1);

	logic                     busy;
	logic [COUNT_BITS-1:0]    count;
	logic                     accept;
	logic [MEM_ADDR_BITS-1:0] word_address;

	assign accept       = i_request && !busy;
	assign word_address = i_address[BYTE_OFFSET_BITS +: MEM_ADDR_BITS];

	// Address is held by the requester, so the registered read settles before ready.
	cpu_bram_1r1w #(
		.WIDTH(WORD_BITS),
		.DEPTH(1 << MEM_ADDR_BITS)
	) u_array (
		.i_clock(i_clock),
		.i_read_address(word_address),
		.o_read_data(o_rdata),
		.i_write_request(accept && i_write),
		.i_write_address(word_address),
		.i_write_data(i_wdata)
	);

	// Count down from acceptance, ready fires when the count runs out.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (accept) begin
			busy  <= 1'b1;
			count <= COUNT_BITS'(MEM_LATENCY - 1);
		end else if (busy) begin
			if (count == '0) begin
				busy <= 1'b0;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	assign o_ready = busy && (count == '0);

endmodule

`default_nettype wire

//--- verilog/cpu_memory_subsystem.sv
// Memory subsystem top joining the instruction cache, data port, arbiter and memory.
`default_nettype none
`timescale 1ns/1ps

module cpu_memory_subsystem import cpu_pkg::*; #(
	parameter int CACHE_SET_BITS = 6,
	parameter int MEM_ADDR_BITS  = 10,
	parameter int MEM_LATENCY    = 3
) (
	input  logic  i_clock,
	input  logic  i_reset,

	// Instruction fetch.
	input  word_t i_fetch_pc,
	output word_t o_fetch_data,
	output logic  o_fetch_ready,

	// Uncached data port.
	input  logic  i_data_request,
	input  logic  i_data_write,
	input  word_t i_data_address,
	input  word_t i_data_wdata,
	output logic  o_data_ready,
	output word_t o_data_rdata,

	// Debug counters.
	output word_t o_hit_count,
	output word_t o_refill_count
);

	// Cache refill bus.
	logic  fetch_request;
	word_t fetch_address;
	logic  fetch_ready;
	word_t fetch_rdata;

	// Arbitrated memory bus.
	logic  mem_request;
	logic  mem_write;
	word_t mem_address;
	word_t mem_wdata;
	logic  mem_ready;
	word_t mem_rdata;

	cpu_icache #(
		.CACHE_SET_BITS(CACHE_SET_BITS)
	) u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_pc(i_fetch_pc),
		.o_fetch_data(o_fetch_data),
		.o_fetch_ready(o_fetch_ready),
		.o_bus_request(fetch_request),
		.o_bus_address(fetch_address),
		.i_bus_ready(fetch_ready),
		.i_bus_rdata(fetch_rdata),
		.o_hit_count(o_hit_count),
		.o_refill_count(o_refill_count)
	);

	// Data port goes straight to the arbiter.
	cpu_bus_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_request(fetch_request),
		.i_fetch_address(fetch_address),
		.o_fetch_ready(fetch_ready),
		.o_fetch_rdata(fetch_rdata),
		.i_data_request(i_data_request),
		.i_data_write(i_data_write),
		.i_data_address(i_data_address),
		.i_data_wdata(i_data_wdata),
		.o_data_ready(o_data_ready),
		.o_data_rdata(o_data_rdata),
		.o_mem_request(mem_request),
		.o_mem_write(mem_write),
		.o_mem_address(mem_address),
		.o_mem_wdata(mem_wdata),
		.i_mem_ready(mem_ready),
		.i_mem_rdata(mem_rdata)
	);

	cpu_main_memory #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_memory (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(mem_request),
		.i_write(mem_write),
		.i_address(mem_address),
		.i_wdata(mem_wdata),
		.o_ready(mem_ready),
		.o_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
// Shared bus word, bus owner and width definitions for the memory subsystem.
`default_nettype none

package cpu_pkg;

	// Width of one bus word in bits.
	localparam int WORD_BITS = 32;

	// Byte offset bits below the word address.
	localparam int BYTE_OFFSET_BITS = 2;

	// One bus word, used for addresses and data alike.
	typedef logic [WORD_BITS-1:0] word_t;

	// Current owner of the shared memory bus.
	typedef enum logic [1:0] {
		BUS_OWNER_NONE  = 2'd0,
		BUS_OWNER_FETCH = 2'd1,
		BUS_OWNER_DATA  = 2'd2
	} bus_owner_t;

endpackage

`default_nettype wire
